// ==== Makefile ====
# Verilator build and run for the hello-world register block

VERILATOR ?= verilator
TOP       ?= hello_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps

SRCS    := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "No errors" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
design/hello_pkg.sv
design/axil_slave.sv
design/hello_regs.sv
design/vled_ctrl.sv
design/hello_top.sv
test/hello_tb.sv

// ==== design/axil_slave.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Single-beat AXI-Lite slave
// Write FSM turns aw/w beats into register
// writes, read FSM looks up one register
// and holds the response until accepted
// ----------------------------------------

module axil_slave
  import hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output reg_wr_t   reg_wr,
  output addr_t     rd_addr,
  input  data_t     rd_data
);

  wr_state_e wr_state;
  wr_state_e wr_state_nxt;
  rd_state_e rd_state;
  rd_state_e rd_state_nxt;

  // Latched write address
  addr_t wr_addr;
  // Read data captured during lookup
  data_t rdata_q;

  // Handshake strobes
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  assign aw_hs = (wr_state == WR_IDLE) && axil_req.awvalid;
  assign w_hs  = (wr_state == WR_DATA) && axil_req.wvalid;
  assign b_hs  = (wr_state == WR_RESP) && axil_req.bready;

  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE: if (aw_hs) wr_state_nxt = WR_DATA;
      WR_DATA: if (w_hs)  wr_state_nxt = WR_RESP;
      // Response held until host takes it
      WR_RESP: if (b_hs)  wr_state_nxt = WR_IDLE;
      default: wr_state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
      wr_addr  <= '0;
    end else begin
      wr_state <= wr_state_nxt;
      if (aw_hs) begin
        wr_addr <= axil_req.awaddr;
      end
    end
  end

  // Write strobe fires during the data beat itself
  // wstrb is not looked at, full-word writes only
  always_comb begin
    reg_wr.en   = w_hs;
    reg_wr.addr = wr_addr;
    reg_wr.data = axil_req.wdata;
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  assign ar_hs = (rd_state == RD_IDLE) && axil_req.arvalid;
  assign r_hs  = (rd_state == RD_RESP) && axil_req.rready;

  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      RD_IDLE:   if (ar_hs) rd_state_nxt = RD_LOOKUP;
      // One cycle for the register mux
      RD_LOOKUP: rd_state_nxt = RD_RESP;
      RD_RESP:   if (r_hs)  rd_state_nxt = RD_IDLE;
      default:   rd_state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
      rd_addr  <= '0;
      rdata_q  <= '0;
    end else begin
      rd_state <= rd_state_nxt;
      if (ar_hs) begin
        rd_addr <= axil_req.araddr;
      end
      // Sample the mux output while in lookup
      if (rd_state == RD_LOOKUP) begin
        rdata_q <= rd_data;
      end
    end
  end

  // ----------------------------------------
  // Bus outputs
  // ----------------------------------------
  always_comb begin
    // Address channels open only when idle
    axil_rsp.awready = (wr_state == WR_IDLE);
    // Data beat passes straight through in WR_DATA
    axil_rsp.wready  = w_hs;
    axil_rsp.bvalid  = (wr_state == WR_RESP);
    axil_rsp.bresp   = OKAY;
    axil_rsp.arready = (rd_state == RD_IDLE);
    axil_rsp.rvalid  = (rd_state == RD_RESP);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = OKAY;
  end

endmodule

// ==== design/hello_pkg.sv ====
// ----------------------------------------
// Hello-world register block package
// Widths, address map, AXI-Lite bus structs,
// register write struct and FSM enums
// ----------------------------------------

package hello_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int VLED_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [VLED_W-1:0] vled_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t HELLO_ADDR = 32'h0000_0500;
  localparam addr_t VLED_ADDR  = 32'h0000_0504;
  localparam addr_t X_ADDR     = 32'h0000_0510;
  localparam addr_t Y_ADDR     = 32'h0000_0514;
  localparam addr_t Z_ADDR     = 32'h0000_0518;

  // Returned for any unmapped read
  localparam data_t UNIMPL_VALUE = 32'hDEAD_DEAD;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Write path FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Read path FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LOOKUP,
    RD_RESP
  } rd_state_e;

  // ----------------------------------------
  // AXI-Lite channels
  // ----------------------------------------
  // Host side, all channels
  typedef struct packed {
    logic        awvalid;
    addr_t       awaddr;
    logic        wvalid;
    data_t       wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    addr_t       araddr;
    logic        rready;
  } axil_req_t;

  // Slave side, all channels
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    axil_resp_e  bresp;
    logic        arready;
    logic        rvalid;
    data_t       rdata;
    axil_resp_e  rresp;
  } axil_rsp_t;

  // Single register write strobe
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } reg_wr_t;

endpackage

// ==== design/hello_regs.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Hello-world register bank
// hello, x and y registers, z = x + y,
// and the read-data multiplexer
// ----------------------------------------

module hello_regs
  import hello_pkg::*;
(
  input  logic    clk_main_a0,
  input  logic    rst_main_n_sync,
  input  reg_wr_t reg_wr,
  input  addr_t   rd_addr,
  output data_t   rd_data,
  output vled_t   led_src,
  input  vled_t   led_shadow
);

  data_t hello_q;
  data_t x_q;
  data_t y_q;

  // Derived read values
  data_t hello_swapped;
  data_t z_sum;

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else if (reg_wr.en) begin
      case (reg_wr.addr)
        HELLO_ADDR: hello_q <= reg_wr.data;
        X_ADDR:     x_q     <= reg_wr.data;
        Y_ADDR:     y_q     <= reg_wr.data;
        // Read-only and unmapped addresses drop the write
        default: ;
      endcase
    end
  end

  // Byte order reversed on readback
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // Wraps modulo 2^32
  assign z_sum = x_q + y_q;

  // Low half of hello feeds the LED shadow
  assign led_src = hello_q[VLED_W-1:0];

  // ----------------------------------------
  // Read multiplexer
  // ----------------------------------------
  always_comb begin
    case (rd_addr)
      HELLO_ADDR: rd_data = hello_swapped;
      // Shadow zero-extended to bus width
      VLED_ADDR:  rd_data = {{(DATA_W-VLED_W){1'b0}}, led_shadow};
      X_ADDR:     rd_data = x_q;
      Y_ADDR:     rd_data = y_q;
      Z_ADDR:     rd_data = z_sum;
      default:    rd_data = UNIMPL_VALUE;
    endcase
  end

endmodule

// ==== design/hello_top.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Hello-world top level
// AXI-Lite slave, register bank and
// virtual LED block
// ----------------------------------------

module hello_top
  import hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  vled_t     status_vdip,
  output vled_t     status_vled
);

  // Slave to register bank
  reg_wr_t reg_wr;
  addr_t   rd_addr;
  data_t   rd_data;

  // Register bank to LED block and back
  vled_t   led_src;
  vled_t   led_shadow;

  // ----------------------------------------
  // Bus slave
  // ----------------------------------------
  axil_slave u_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Register bank, owns all address decode
  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .led_src         (led_src),
    .led_shadow      (led_shadow)
  );

  // LED shadow and DIP masking
  vled_ctrl u_vled_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_src         (led_src),
    .status_vdip     (status_vdip),
    .led_shadow      (led_shadow),
    .status_vled     (status_vled)
  );

endmodule

// ==== design/vled_ctrl.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Virtual LED block
// Shadows hello[15:0], syncs the DIPs and
// drives LEDs as shadow AND DIPs
// ----------------------------------------

module vled_ctrl
  import hello_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  input  vled_t led_src,
  input  vled_t status_vdip,
  output vled_t led_shadow,
  output vled_t status_vled
);

  // Two-flop DIP synchroniser
  vled_t dip_meta;
  vled_t dip_sync;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_shadow  <= '0;
      dip_meta    <= '0;
      dip_sync    <= '0;
      status_vled <= '0;
    end else begin
      // Shadow trails hello by one cycle
      led_shadow  <= led_src;
      dip_meta    <= status_vdip;
      dip_sync    <= dip_meta;
      // DIP low blanks the matching LED
      status_vled <= led_shadow & dip_sync;
    end
  end

endmodule

// ==== include/hello_tb_tasks.svh ====
// ----------------------------------------
// Testbench bus and compare tasks
// Single-beat AXI-Lite write and read with
// random response stalls, typed checks
// ----------------------------------------
`ifndef HELLO_TB_TASKS_SVH
`define HELLO_TB_TASKS_SVH

// Response stall of 0 to 3 cycles
function automatic int random_stall();
  return int'($unsigned($random(seed)) % 32'd4);
endfunction

// aw beat, then w beat, then b with bready held off
task automatic bus_write(input addr_t addr, input data_t data, output axil_resp_e resp);
  int stall;
  @(negedge clk_main_a0);
  axil_req.awvalid = 1'b1;
  axil_req.awaddr  = addr;
  // awready depends on state only
  while (!axil_rsp.awready) @(negedge clk_main_a0);
  @(negedge clk_main_a0);
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b1;
  axil_req.wdata   = data;
  axil_req.wstrb   = 4'hF;
  // wready follows wvalid, let it settle
  #1;
  while (!axil_rsp.wready) begin
    @(negedge clk_main_a0);
    #1;
  end
  @(negedge clk_main_a0);
  axil_req.wvalid = 1'b0;
  while (!axil_rsp.bvalid) @(negedge clk_main_a0);
  stall = random_stall();
  repeat (stall) @(negedge clk_main_a0);
  if (!axil_rsp.bvalid) begin
    $display("bvalid dropped while bready was held low");
    err_cnt++;
  end
  resp = axil_rsp.bresp;
  axil_req.bready = 1'b1;
  @(negedge clk_main_a0);
  axil_req.bready = 1'b0;
endtask

// ar beat, then r with rready held off
task automatic bus_read(input addr_t addr, output data_t data, output axil_resp_e resp);
  int stall;
  @(negedge clk_main_a0);
  axil_req.arvalid = 1'b1;
  axil_req.araddr  = addr;
  while (!axil_rsp.arready) @(negedge clk_main_a0);
  @(negedge clk_main_a0);
  axil_req.arvalid = 1'b0;
  while (!axil_rsp.rvalid) @(negedge clk_main_a0);
  stall = random_stall();
  repeat (stall) @(negedge clk_main_a0);
  if (!axil_rsp.rvalid) begin
    $display("rvalid dropped while rready was held low");
    err_cnt++;
  end
  // Sampled at the handshake, after the stall
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  axil_req.rready = 1'b1;
  @(negedge clk_main_a0);
  axil_req.rready = 1'b0;
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
  if (act !== exp) begin
    $display("mismatch %s expected %08h actual %08h", name, exp, act);
    err_cnt++;
  end
endtask

task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
  if (act !== exp) begin
    $display("mismatch %s expected %01h actual %01h", name, exp, act);
    err_cnt++;
  end
endtask

task automatic check_vled(input string name, input vled_t exp, input vled_t act);
  if (act !== exp) begin
    $display("mismatch %s expected %04h actual %04h", name, exp, act);
    err_cnt++;
  end
endtask

`endif

// ==== test/hello_tb.sv ====
`timescale 1ns/1ps
// ----------------------------------------
// Testbench for the hello-world block
// Table of AXI-Lite writes, reads and DIP
// changes applied with random back-pressure
// ----------------------------------------

module hello_tb
  import hello_pkg::*;
();

  // Table operations
  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_DIP
  } op_e;

  // One table row, wdata doubles as the DIP value
  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t wdata;
    data_t exp_data;
    vled_t exp_vled;
  } entry_t;

  localparam int N_ENTRIES = 34;
  // Per-entry budget plus reset and slack
  localparam int TIMEOUT_CYCLES = 40 * N_ENTRIES + 100;
  localparam addr_t UNMAPPED_ADDR = 32'h0000_0600;

  logic      clk_main_a0 = 1'b0;
  logic      rst_main_n_sync;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  vled_t     status_vdip;
  vled_t     status_vled;

  entry_t table_mem [N_ENTRIES];
  int     fill_idx  = 0;
  int     err_cnt   = 0;
  int     pass_cnt  = 0;
  int     fail_cnt  = 0;
  int     cycle_cnt = 0;
  int     seed      = 32'h1371;

  `include "hello_tb_tasks.svh"

  hello_top DUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  // 8 ns clock
  initial begin
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  always @(posedge clk_main_a0) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: a bus handshake did not complete within %0d cycles",
               TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic add_entry(input op_e op, input addr_t addr, input data_t wdata,
                           input data_t exp_data, input vled_t exp_vled);
    table_mem[fill_idx] = '{op, addr, wdata, exp_data, exp_vled};
    fill_idx++;
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic load_table();
    // Everything reads zero out of reset
    add_entry(OP_READ,  HELLO_ADDR, 32'h0, 32'h0, 16'h0);
    add_entry(OP_READ,  X_ADDR,     32'h0, 32'h0, 16'h0);
    add_entry(OP_READ,  Y_ADDR,     32'h0, 32'h0, 16'h0);
    add_entry(OP_READ,  Z_ADDR,     32'h0, 32'h0, 16'h0);
    add_entry(OP_READ,  VLED_ADDR,  32'h0, 32'h0, 16'h0);
    // Hello reads byte-swapped, DIPs still all low
    add_entry(OP_WRITE, HELLO_ADDR, 32'h1234_5678, 32'h0, 16'h0);
    add_entry(OP_READ,  HELLO_ADDR, 32'h0, 32'h7856_3412, 16'h0);
    // All DIPs on, LEDs show hello[15:0]
    add_entry(OP_DIP,   32'h0, 32'h0000_FFFF, 32'h0, 16'h5678);
    add_entry(OP_READ,  VLED_ADDR,  32'h0, 32'h0000_5678, 16'h5678);
    // 0x5678 & 0x0F0F, shadow read stays unmasked
    add_entry(OP_DIP,   32'h0, 32'h0000_0F0F, 32'h0, 16'h0608);
    add_entry(OP_READ,  VLED_ADDR,  32'h0, 32'h0000_5678, 16'h0608);
    // Plain sum
    add_entry(OP_WRITE, X_ADDR,     32'h0000_1000, 32'h0, 16'h0608);
    add_entry(OP_WRITE, Y_ADDR,     32'h0000_0234, 32'h0, 16'h0608);
    add_entry(OP_READ,  Z_ADDR,     32'h0, 32'h0000_1234, 16'h0608);
    add_entry(OP_READ,  X_ADDR,     32'h0, 32'h0000_1000, 16'h0608);
    add_entry(OP_READ,  Y_ADDR,     32'h0, 32'h0000_0234, 16'h0608);
    // Sum wraps past 2^32
    add_entry(OP_WRITE, X_ADDR,     32'hFFFF_FFF0, 32'h0, 16'h0608);
    add_entry(OP_WRITE, Y_ADDR,     32'h0000_0020, 32'h0, 16'h0608);
    add_entry(OP_READ,  Z_ADDR,     32'h0, 32'h0000_0010, 16'h0608);
    add_entry(OP_READ,  X_ADDR,     32'h0, 32'hFFFF_FFF0, 16'h0608);
    // Unmapped and read-only targets
    add_entry(OP_READ,  UNMAPPED_ADDR, 32'h0, UNIMPL_VALUE, 16'h0608);
    add_entry(OP_WRITE, UNMAPPED_ADDR, 32'hAAAA_5555, 32'h0, 16'h0608);
    add_entry(OP_WRITE, Z_ADDR,     32'h0000_0001, 32'h0, 16'h0608);
    add_entry(OP_WRITE, VLED_ADDR,  32'hFFFF_FFFF, 32'h0, 16'h0608);
    // Nothing above may have moved
    add_entry(OP_READ,  HELLO_ADDR, 32'h0, 32'h7856_3412, 16'h0608);
    add_entry(OP_READ,  X_ADDR,     32'h0, 32'hFFFF_FFF0, 16'h0608);
    add_entry(OP_READ,  Y_ADDR,     32'h0, 32'h0000_0020, 16'h0608);
    add_entry(OP_READ,  Z_ADDR,     32'h0, 32'h0000_0010, 16'h0608);
    add_entry(OP_READ,  VLED_ADDR,  32'h0, 32'h0000_5678, 16'h0608);
    // New hello under the 0x0F0F mask, 0xBEEF & 0x0F0F
    add_entry(OP_WRITE, HELLO_ADDR, 32'hCAFE_BEEF, 32'h0, 16'h0E0F);
    add_entry(OP_READ,  HELLO_ADDR, 32'h0, 32'hEFBE_FECA, 16'h0E0F);
    add_entry(OP_DIP,   32'h0, 32'h0000_FFFF, 32'h0, 16'hBEEF);
    add_entry(OP_READ,  VLED_ADDR,  32'h0, 32'h0000_BEEF, 16'hBEEF);
    add_entry(OP_READ,  32'h0000_051C, 32'h0, UNIMPL_VALUE, 16'hBEEF);
  endtask

  task automatic apply_entry(input int idx);
    entry_t     e;
    data_t      rd;
    axil_resp_e resp;
    int         err_before;
    e          = table_mem[idx];
    err_before = err_cnt;
    case (e.op)
      OP_WRITE: begin
        bus_write(e.addr, e.wdata, resp);
        check_resp("bresp", OKAY, resp);
      end
      OP_READ: begin
        bus_read(e.addr, rd, resp);
        check_resp("rresp", OKAY, resp);
        check_data("rdata", e.exp_data, rd);
      end
      default: begin
        @(negedge clk_main_a0);
        status_vdip = e.wdata[VLED_W-1:0];
      end
    endcase
    // LED path needs 3 cycles to settle
    repeat (4) @(negedge clk_main_a0);
    check_vled("status_vled", e.exp_vled, status_vled);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %0d %s addr %08h ok", idx, e.op.name(), e.addr);
    end else begin
      fail_cnt++;
      $display("test %0d %s addr %08h failed", idx, e.op.name(), e.addr);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    axil_req        = '0;
    status_vdip     = '0;
    rst_main_n_sync = 1'b0;
    load_table();
    repeat (5) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    for (int i = 0; i < N_ENTRIES; i++) begin
      apply_entry(i);
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             N_ENTRIES, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
